/* dv/ls_stimulus.txt */
# op (1 load, 2 store), rs1, imm, rs2 (store data), expected load, expected misaligned
# all fields hex; address is rs1 + imm, word index is address bits 7:2 of 64 words
1 00000000 00000000 00000000 00000000 0
1 00000100 0000003c 00000000 00000000 0
1 ffffff00 000000fc 00000000 00000000 0
2 00001000 00000010 deadbeef 00000000 0
1 00001008 00000008 00000000 deadbeef 0
1 00001020 fffffff0 00000000 deadbeef 0
2 00000040 00000000 12345678 00000000 0
1 00000000 00000040 00000000 12345678 0
2 00000080 00000004 a5a5a5a5 00000000 0
1 00000084 00000000 00000000 a5a5a5a5 0
2 00000000 00000008 11111111 00000000 0
2 00000000 0000000c 22222222 00000000 0
2 00000000 00000014 33333333 00000000 0
1 00000000 00000008 00000000 11111111 0
1 00000000 0000000c 00000000 22222222 0
1 00000000 00000014 00000000 33333333 0
1 00000000 00000010 00000000 deadbeef 0
2 00000000 00000020 cafef00d 00000000 0
2 00000100 00000020 0badf00d 00000000 0
1 00000000 00000020 00000000 0badf00d 0
1 00000200 00000020 00000000 0badf00d 0
1 00000000 00000024 00000000 00000000 0
1 00000000 0000001c 00000000 00000000 0
1 00000000 00000008 00000000 11111111 0
2 000000fc 00000000 77777777 00000000 0
1 00000000 00000000 00000000 00000000 0
1 fffffffc 00000000 00000000 77777777 0
2 00000000 00000031 99999999 00000000 1
1 00000000 00000030 00000000 00000000 0
2 00000032 00000000 88888888 00000000 1
2 00000001 00000002 66666666 00000000 1
1 00000030 00000000 00000000 00000000 0
1 00000041 00000000 00000000 00000000 1
2 00000006 0000000a 44444444 00000000 0
1 00001010 00000000 00000000 44444444 0
2 00000010 ffffffff 55555555 00000000 1
1 00000010 00000000 00000000 44444444 0
2 00000000 00000080 01020304 00000000 0
2 00000000 00000088 05060708 00000000 0
1 00000000 00000084 00000000 a5a5a5a5 0
1 00000040 00000040 00000000 01020304 0
1 00000090 fffffff8 00000000 05060708 0
2 00000040 00000000 fedcba98 00000000 0
1 00000000 00000040 00000000 fedcba98 0
1 00000000 00000044 00000000 00000000 0
2 00000000 00000044 13579bdf 00000000 0
1 00000000 00000044 00000000 13579bdf 0
1 00000000 00000040 00000000 fedcba98 0

/* dv/scalar_ls_tb.sv */
`timescale 1ns/1ps

module scalar_ls_tb
    import isa_pkg::*;
    import datapath_pkg::*;
();

    localparam int WAIT_CYCLES = 2;
    localparam int DMEM_WORDS  = 64;

    // one line of the stimulus file.
    typedef struct packed {
        logic [1:0] op;        // 1 is a load, 2 is a store.
        word_t      rs1;
        word_t      imm;
        word_t      rs2;
        word_t      exp_load;
        logic       exp_mis;
    } stim_line_t;

    logic     CLK;
    logic     nRST;
    logic     req_valid;
    ls_req_t  req;
    logic     resp_ready;
    logic     req_ready;
    logic     resp_valid;
    ls_resp_t resp;

    stim_line_t stim_q[$];
    int         pending[$];   // line numbers of accepted requests, oldest first.
    bit         stim_loaded;
    int         value_errors;
    int         protocol_errors;
    int         setup_errors;
    int         sent_count;
    int         resp_count;
    logic       held;
    ls_resp_t   held_resp;

    scalar_ls_top #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .DMEM_WORDS  (DMEM_WORDS)
    ) i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .req_valid  (req_valid),
        .req        (req),
        .resp_ready (resp_ready),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic load_stimulus();
        int          fd;
        int          code;
        int          fields;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_rs1;
        logic [31:0] f_imm;
        logic [31:0] f_rs2;
        logic [31:0] f_load;
        logic [31:0] f_mis;
        stim_line_t  s;
        fd = $fopen("dv/ls_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file dv/ls_stimulus.txt");
            setup_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h",
                                 f_op, f_rs1, f_imm, f_rs2, f_load, f_mis);
                if (fields == 6) begin
                    s.op       = f_op[1:0];
                    s.rs1      = f_rs1;
                    s.imm      = f_imm;
                    s.rs2      = f_rs2;
                    s.exp_load = f_load;
                    s.exp_mis  = f_mis[0];
                    stim_q.push_back(s);
                end else if (fields > 0) begin
                    $display("a stimulus line has only %0d of its 6 fields", fields);
                    setup_errors++;
                end
            end
        end
        $fclose(fd);
        if (stim_q.size() == 0) begin
            $display("the stimulus file holds no requests");
            setup_errors++;
        end
    endtask

    task automatic check_response(input int n);
        stim_line_t s;
        logic       exp_store;
        s = stim_q[n];
        exp_store = (s.op == 2'd2); // the latched type decides is_store, aligned or not.
        if (resp.load !== s.exp_load) begin
            $display("Error: at %0d ns resp.load expected %h, actual %h (line %0d)",
                     $time, s.exp_load, resp.load, n);
            value_errors++;
        end
        if (resp.is_store !== exp_store) begin
            $display("Error: at %0d ns resp.is_store expected %b, actual %b (line %0d)",
                     $time, exp_store, resp.is_store, n);
            value_errors++;
        end
        if (resp.misaligned !== s.exp_mis) begin
            $display("Error: at %0d ns resp.misaligned expected %b, actual %b (line %0d)",
                     $time, s.exp_mis, resp.misaligned, n);
            value_errors++;
        end
    endtask

    task automatic print_counts();
        $display("checks done: %0d value errors, %0d protocol errors, %0d setup errors",
                 value_errors, protocol_errors, setup_errors);
    endtask

    // random back-pressure on the response channel.
    initial begin
        logic [31:0] rng_state;
        rng_state = 32'h9120;
        resp_ready <= 1'b0;
        forever begin
            @(posedge CLK);
            rng_state = lcg_step(rng_state);
            resp_ready <= rng_state[16];
        end
    end

    always @(posedge CLK) begin
        int n;
        if (nRST) begin
            if (held && !resp_valid) begin
                $display("at %0d ns resp_valid dropped before the stalled response was taken",
                         $time);
                protocol_errors++;
            end
            if (held && resp_valid && resp !== held_resp) begin
                $display("Error: at %0d ns resp expected %h, actual %h", $time, held_resp, resp);
                value_errors++;
            end
            if (resp_valid && resp_ready) begin
                if (pending.size() == 0) begin
                    $display("at %0d ns a response came back with no request outstanding", $time);
                    protocol_errors++;
                end else begin
                    n = pending.pop_front();
                    check_response(n);
                    resp_count++;
                end
            end
            if (req_valid && req_ready) begin
                if (pending.size() != 0) begin
                    $display("at %0d ns a request was accepted while a response was pending",
                             $time);
                    protocol_errors++;
                end
                pending.push_back(sent_count);
                sent_count++;
            end
            held      = resp_valid && !resp_ready; // resp must stay put until taken.
            held_resp = resp;
        end
    end

    initial begin
        int         n;
        stim_line_t s;
        ls_req_t    next_req;
        nRST      <= 1'b0;
        req_valid <= 1'b0;
        req       <= '0;
        load_stimulus();
        stim_loaded = 1'b1;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        @(posedge CLK);
        if (req_ready !== 1'b1 || resp_valid !== 1'b0) begin
            $display("after reset req_ready is %b and resp_valid is %b, expected 1 and 0",
                     req_ready, resp_valid);
            setup_errors++;
        end
        for (n = 0; n < stim_q.size(); n++) begin
            s = stim_q[n];
            next_req.mem_type = mem_type_t'(s.op);
            next_req.rs1      = s.rs1;
            next_req.rs2      = s.rs2;
            next_req.imm      = s.imm;
            req_valid <= 1'b1;
            req       <= next_req;
            @(posedge CLK);
            while (!req_ready) begin // held until the DUT takes it.
                @(posedge CLK);
            end
        end
        req_valid <= 1'b0;
        req       <= '0;
        while (resp_count < stim_q.size()) begin
            @(posedge CLK);
        end
        repeat (4) @(posedge CLK);
        if (resp_valid !== 1'b0 || req_ready !== 1'b1) begin
            $display("at the end resp_valid is %b and req_ready is %b, expected 0 and 1",
                     resp_valid, req_ready);
            protocol_errors++;
        end
        print_counts();
        if (value_errors + protocol_errors + setup_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        int cycles;
        int cycle_limit;
        cycles = 0;
        wait (stim_loaded);
        cycle_limit = stim_q.size() * (WAIT_CYCLES + 2) * 8 + 100;
        while (cycles < cycle_limit) begin
            @(posedge CLK);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        print_counts();
        $display("Regression failed");
        $finish;
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the load/store unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module scalar_ls_tb -o scalar_ls_sim
output=$(./obj_dir/scalar_ls_sim)
echo "$output"

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

/* sim.f */
src/datapath_pkg.sv
src/isa_pkg.sv
src/ls_ctrl_fsm.sv
src/ls_addr_latch.sv
src/dmem_wait_timer.sv
src/dmem_bank.sv
src/scalar_ls_top.sv
dv/scalar_ls_tb.sv

/* src/datapath_pkg.sv */
package datapath_pkg;

    // one data word; byte addresses use the same width.
    typedef logic [31:0] word_t;

    // request toward the data memory.
    // ren and wen are only high while an access is in flight.
    typedef struct packed {
        word_t addr;   // byte address, word aligned.
        word_t store;  // write data.
        logic  ren;
        logic  wen;
    } dmem_req_t;

    // response returned to the issue side.
    typedef struct packed {
        word_t load;        // zero for stores and misaligned requests.
        logic  is_store;
        logic  misaligned;  // set when the request touched no memory.
    } ls_resp_t;

endpackage

/* src/dmem_bank.sv */
`timescale 1ns/1ps

module dmem_bank
    import datapath_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  logic      CLK,
    input  logic      nRST,
    input  dmem_req_t dmem_req,
    input  logic      dhit,
    output word_t     dmem_load
);

    localparam int IW = $clog2(DMEM_WORDS);

    word_t         mem [DMEM_WORDS];
    logic [IW-1:0] idx;

    // word index; upper address bits alias onto the same word.
    assign idx = dmem_req.addr[IW+1:2];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (dhit && dmem_req.wen) begin
            mem[idx] <= dmem_req.store;
        end
    end

    // read is combinational; the latch samples it on dhit.
    always_comb begin
        if (dmem_req.ren) begin
            dmem_load = mem[idx];
        end else begin
            dmem_load = '0;
        end
    end

endmodule

/* src/dmem_wait_timer.sv */
`timescale 1ns/1ps

module dmem_wait_timer #(
    parameter int WAIT_CYCLES = 2
) (
    input  logic CLK,
    input  logic nRST,
    input  logic timer_start,
    output logic dhit
);

    localparam int CW = $clog2(WAIT_CYCLES + 1);

    logic [CW-1:0] count;

    // the count is loaded one cycle after the access is launched.
    // dhit is registered, so it appears one edge after the count reaches one.
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
            dhit  <= 1'b0;
        end else if (timer_start) begin
            count <= CW'(WAIT_CYCLES);
            dhit  <= 1'b0;
        end else begin
            if (count != '0) begin
                count <= count - CW'(1);
            end
            dhit <= (count == CW'(1)); // exactly one cycle per access.
        end
    end

endmodule

/* src/isa_pkg.sv */
package isa_pkg;

    import datapath_pkg::*;

    // memory operation carried by an issued instruction.
    typedef enum logic [1:0] {
        MEM_NONE,
        LOAD,
        STORE
    } mem_type_t;

    // operands of one issued load or store.
    // the effective address is rs1 + imm; rs2 is the store data.
    typedef struct packed {
        mem_type_t mem_type;
        word_t     rs1;
        word_t     rs2;
        word_t     imm;
    } ls_req_t;

endpackage

/* src/ls_addr_latch.sv */
`timescale 1ns/1ps

module ls_addr_latch
    import isa_pkg::*;
    import datapath_pkg::*;
(
    input  logic      CLK,
    input  logic      nRST,
    input  logic      capture,
    input  logic      mem_active,
    input  logic      dhit,
    input  ls_req_t   req,
    input  word_t     dmem_load,
    output logic      misaligned,
    output dmem_req_t dmem_req,
    output ls_resp_t  resp
);

    word_t     eff_addr;
    word_t     addr_q;
    word_t     store_q;
    word_t     load_q;
    mem_type_t op_q;
    logic      mis_q;

    assign eff_addr   = req.rs1 + req.imm;
    assign misaligned = (eff_addr[1:0] != 2'b00); // checked on the incoming request.

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            op_q  <= MEM_NONE;
            mis_q <= 1'b0;
        end else if (capture) begin
            op_q  <= req.mem_type;
            mis_q <= misaligned;
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            addr_q  <= eff_addr;
            store_q <= req.rs2;
            load_q  <= '0; // stays zero unless a load hits.
        end else if (dhit) begin
            load_q  <= dmem_load;
        end
    end

    always_comb begin
        dmem_req.addr  = addr_q;
        dmem_req.store = store_q;
        dmem_req.ren   = mem_active && (op_q == LOAD);
        dmem_req.wen   = mem_active && (op_q == STORE);
    end

    always_comb begin
        resp.load       = load_q;
        resp.is_store   = (op_q == STORE);
        resp.misaligned = mis_q;
    end

endmodule

/* src/ls_ctrl_fsm.sv */
`timescale 1ns/1ps

module ls_ctrl_fsm (
    input  logic CLK,
    input  logic nRST,
    input  logic req_valid,
    input  logic resp_ready,
    input  logic misaligned,
    input  logic dhit,
    output logic req_ready,
    output logic resp_valid,
    output logic capture,
    output logic mem_active,
    output logic timer_start
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } state_t;

    state_t state;
    state_t next_state;
    logic   start_q;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state   <= IDLE;
            start_q <= 1'b0;
        end else begin
            state   <= next_state;
            start_q <= capture && !misaligned; // first cycle of ACCESS.
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // a misaligned address never reaches the memory.
                if (req_valid) begin
                    if (misaligned) begin
                        next_state = RESPOND;
                    end else begin
                        next_state = ACCESS;
                    end
                end
            end
            ACCESS: begin
                if (dhit) begin
                    next_state = RESPOND;
                end
            end
            RESPOND: begin
                if (resp_ready) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // one request at a time, so ready only while nothing is held.
    assign req_ready   = (state == IDLE);
    assign capture     = req_ready && req_valid;
    assign mem_active  = (state == ACCESS);
    assign resp_valid  = (state == RESPOND);
    assign timer_start = start_q;

endmodule

/* src/scalar_ls_top.sv */
`timescale 1ns/1ps

module scalar_ls_top
    import isa_pkg::*;
    import datapath_pkg::*;
#(
    parameter int WAIT_CYCLES = 2,
    parameter int DMEM_WORDS  = 64
) (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     req_valid,
    input  ls_req_t  req,
    input  logic     resp_ready,
    output logic     req_ready,
    output logic     resp_valid,
    output ls_resp_t resp
);

    logic      capture;
    logic      misaligned;
    logic      mem_active;
    logic      timer_start;
    logic      dhit;
    dmem_req_t dmem_req;
    word_t     dmem_load;

    ls_ctrl_fsm i_ctrl (
        .CLK         (CLK),
        .nRST        (nRST),
        .req_valid   (req_valid),
        .resp_ready  (resp_ready),
        .misaligned  (misaligned),
        .dhit        (dhit),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .capture     (capture),
        .mem_active  (mem_active),
        .timer_start (timer_start)
    );

    ls_addr_latch i_latch (
        .CLK        (CLK),
        .nRST       (nRST),
        .capture    (capture),
        .mem_active (mem_active),
        .dhit       (dhit),
        .req        (req),
        .dmem_load  (dmem_load),
        .misaligned (misaligned),
        .dmem_req   (dmem_req),
        .resp       (resp)
    );

    dmem_wait_timer #(
        .WAIT_CYCLES (WAIT_CYCLES)
    ) i_timer (
        .CLK         (CLK),
        .nRST        (nRST),
        .timer_start (timer_start),
        .dhit        (dhit)
    );

    dmem_bank #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_bank (
        .CLK       (CLK),
        .nRST      (nRST),
        .dmem_req  (dmem_req),
        .dhit      (dhit),
        .dmem_load (dmem_load)
    );

endmodule
